// File: hw/lsu_pkg.sv
// 32-bit little endian data port with four byte lanes, size code 2'b11 is decoded as a byte access
`default_nettype none

package lsu_pkg;

  ////////////////////////////// widths

  localparam int unsigned XLEN     = 32;              // data and address width
  localparam int unsigned BYTE_W   = 8;               // bits per byte lane
  localparam int unsigned NB_LANES = XLEN / BYTE_W;   // bytes per word
  localparam int unsigned OFFS_W   = $clog2(NB_LANES); // byte offset inside a word

  ////////////////////////////// encodings

  // access size as decoded in the execute stage
  typedef enum logic [1:0] {
    SIZE_WORD = 2'b00,
    SIZE_HALF = 2'b01,
    SIZE_BYTE = 2'b10
  } lsu_size_e;

  // fill applied to the upper bits of a narrow load
  typedef enum logic [1:0] {
    EXT_ZERO = 2'b00,
    EXT_SIGN = 2'b01,
    EXT_ONES = 2'b10
  } lsu_ext_e;

  // request FSM states
  typedef enum logic [1:0] {
    ST_IDLE              = 2'b00, // nothing outstanding
    ST_WAIT_RVALID       = 2'b01, // granted, ex stage moved on
    ST_WAIT_RVALID_STALL = 2'b10, // granted while ex stage stalled
    ST_IDLE_STALL        = 2'b11  // data back, ex stage still stalled
  } lsu_state_e;

  ////////////////////////////// bundles

  // request from the execute stage
  typedef struct packed {
    logic            we;       // store when set
    lsu_size_e       size;
    lsu_ext_e        ext;
    logic [XLEN-1:0] op_a;     // base
    logic [XLEN-1:0] op_b;     // offset, only with use_incr
    logic            use_incr; // address is op_a + op_b
    logic [XLEN-1:0] wdata;    // store data, unrotated
  } lsu_req_t;

  // payload toward the data memory
  typedef struct packed {
    logic [XLEN-1:0]     addr;
    logic                we;
    logic [NB_LANES-1:0] be;
    logic [XLEN-1:0]     wdata; // already in its byte lanes
  } mem_req_t;

  // what the load path needs once the grant is seen
  typedef struct packed {
    logic              we;
    lsu_size_e         size;
    lsu_ext_e          ext;
    logic [OFFS_W-1:0] offset;
  } rd_ctx_t;

endpackage

`default_nettype wire

// File: hw/lsu_req_fmt.sv
// purely combinational, misaligned requests are only flagged and their payload is not meaningful
`timescale 1ns/1ps
`default_nettype none

module lsu_req_fmt
  import lsu_pkg::*;
(
  input  lsu_req_t ex_req_i,     // request from ex stage
  output mem_req_t mem_req_o,    // payload toward memory
  output rd_ctx_t  ctx_o,        // load context, latched at grant downstream
  output logic     misaligned_o  // access crosses a word boundary
);

  logic [XLEN-1:0]     addr;      // effective address
  logic [OFFS_W-1:0]   offset;    // byte offset inside the word
  logic [NB_LANES-1:0] be;
  logic [XLEN-1:0]     wdata_rot; // store data moved to its lanes

  ////////////////////////////// address

  // base only, or base plus increment
  assign addr   = ex_req_i.use_incr ? (ex_req_i.op_a + ex_req_i.op_b) : ex_req_i.op_a;
  assign offset = addr[OFFS_W-1:0];

  ////////////////////////////// byte enables

  always_comb
  begin
    case (ex_req_i.size)
      SIZE_WORD:
      begin
        be = '1; // aligned words only, all lanes
      end
      SIZE_HALF:
      begin
        be = NB_LANES'(2'b11) << offset; // two adjacent lanes
      end
      default:
      begin
        be = NB_LANES'(1'b1) << offset;  // byte, one lane
      end
    endcase
  end

  ////////////////////////////// store data

  // rotate left by whole bytes so byte 0 of wdata lands in the addressed lane
  assign wdata_rot = (ex_req_i.wdata << (offset * BYTE_W))
                   | (ex_req_i.wdata >> ((NB_LANES - offset) * BYTE_W));

  ////////////////////////////// boundary check

  always_comb
  begin
    case (ex_req_i.size)
      SIZE_WORD:
      begin
        misaligned_o = (offset != '0); // any nonzero offset spills over
      end
      SIZE_HALF:
      begin
        misaligned_o = (offset == '1); // only the top lane spills
      end
      default:
      begin
        misaligned_o = 1'b0;           // a byte never crosses
      end
    endcase
  end

  ////////////////////////////// outputs

  assign mem_req_o.addr  = addr;
  assign mem_req_o.we    = ex_req_i.we;
  assign mem_req_o.be    = be;
  assign mem_req_o.wdata = wdata_rot;

  // everything the read path has to remember
  assign ctx_o.we     = ex_req_i.we;
  assign ctx_o.size   = ex_req_i.size;
  assign ctx_o.ext    = ex_req_i.ext;
  assign ctx_o.offset = offset;

endmodule

`default_nettype wire

// File: hw/lsu_ctrl_fsm.sv
// one access outstanding at a time, rvalid must come at least one cycle after its grant
`timescale 1ns/1ps
`default_nettype none

module lsu_ctrl_fsm
  import lsu_pkg::*;
(
  input  logic clk,
  input  logic rst_n,

  input  logic ex_req_valid_i,  // request strobe from ex stage
  input  logic misaligned_i,    // current request crosses a word

  input  logic mem_gnt_i,
  input  logic mem_rvalid_i,
  input  logic mem_err_i,

  input  logic ex_valid_i,      // ex stage is advancing this cycle

  output logic mem_req_valid_o,
  output logic ready_ex_o,      // request consumed or dropped
  output logic ready_wb_o,      // no load pending for wb
  output logic busy_o
);

  lsu_state_e state_q;
  lsu_state_e state_d;

  logic       req_ok;      // request that may actually go out
  logic       issue_ready; // ready_ex whenever the FSM is allowed to issue
  lsu_state_e gnt_state;   // where a grant sends us

  ////////////////////////////// issue helpers

  // misaligned requests never reach the bus
  assign req_ok = ex_req_valid_i & ~misaligned_i;

  // no request, a dropped one, a grant or a bus error all free the ex stage
  assign issue_ready = ~req_ok | mem_gnt_i | mem_err_i;

  // a stalled ex stage has to see the rvalid before we move on
  assign gnt_state = ex_valid_i ? ST_WAIT_RVALID : ST_WAIT_RVALID_STALL;

  ////////////////////////////// next state and outputs

  always_comb
  begin
    state_d         = state_q;
    mem_req_valid_o = 1'b0;
    ready_ex_o      = ~ex_req_valid_i; // a waiting request holds ex
    ready_wb_o      = 1'b1;

    case (state_q)
      ST_IDLE:
      begin
        mem_req_valid_o = req_ok;
        ready_ex_o      = issue_ready;
        if (req_ok && mem_gnt_i)
        begin
          state_d = gnt_state;
        end
      end

      ST_WAIT_RVALID:
      begin
        ready_wb_o = 1'b0; // load result still missing
        if (mem_rvalid_i)
        begin
          // data is back, so a new request may go out right now
          ready_wb_o      = 1'b1;
          mem_req_valid_o = req_ok;
          ready_ex_o      = issue_ready;
          if (req_ok && mem_gnt_i)
            state_d = gnt_state;
          else
            state_d = ST_IDLE; // nothing, dropped or bus error
        end
      end

      ST_WAIT_RVALID_STALL:
      begin
        // no new requests while ex is held
        if (mem_rvalid_i)
          state_d = ex_valid_i ? ST_IDLE : ST_IDLE_STALL;
        else if (ex_valid_i)
          state_d = ST_WAIT_RVALID;
      end

      ST_IDLE_STALL:
      begin
        if (ex_valid_i)
          state_d = ST_IDLE; // stall lifted
      end

      default:
      begin
        state_d = ST_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      state_q <= ST_IDLE;
    else
      state_q <= state_d;
  end

  // anything in flight or about to be
  assign busy_o = (state_q != ST_IDLE) | mem_req_valid_o;

endmodule

`default_nettype wire

// File: hw/lsu_rdata_align.sv
// context is taken on every grant, so grants must only come for issued requests
`timescale 1ns/1ps
`default_nettype none

module lsu_rdata_align
  import lsu_pkg::*;
(
  input  logic            clk,
  input  logic            rst_n,

  input  rd_ctx_t         ctx_i,        // context of the request on the bus
  input  logic            mem_gnt_i,
  input  logic            mem_rvalid_i,
  input  logic [XLEN-1:0] mem_rdata_i,

  output logic [XLEN-1:0] ex_rdata_o    // to register file write-back
);

  rd_ctx_t         ctx_q;       // context of the outstanding access
  logic [XLEN-1:0] rdata_sh;    // addressed lane moved down to bit 0
  logic            fill;        // bit for the upper part
  logic [XLEN-1:0] rdata_ext;   // aligned and extended result
  logic [XLEN-1:0] rdata_q;     // last load result
  logic            load_rvalid; // data of a load is on the bus

  ////////////////////////////// context capture

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      ctx_q <= '0;
    else if (mem_gnt_i)
      ctx_q <= ctx_i; // request accepted, remember how to treat the data
  end

  ////////////////////////////// alignment

  // word loads are aligned here, so shifting by the offset covers every size
  assign rdata_sh = mem_rdata_i >> (ctx_q.offset * BYTE_W);

  always_comb
  begin
    case (ctx_q.ext)
      EXT_SIGN:
      begin
        if (ctx_q.size == SIZE_HALF)
          fill = rdata_sh[2*BYTE_W-1];
        else
          fill = rdata_sh[BYTE_W-1];
      end
      EXT_ONES:
      begin
        fill = 1'b1;
      end
      default:
      begin
        fill = 1'b0;  // zero extension
      end
    endcase
  end

  always_comb
  begin
    case (ctx_q.size)
      SIZE_WORD:
      begin
        rdata_ext = rdata_sh; // no fill for full words
      end
      SIZE_HALF:
      begin
        rdata_ext = {{(XLEN-2*BYTE_W){fill}}, rdata_sh[2*BYTE_W-1:0]};
      end
      default:
      begin
        rdata_ext = {{(XLEN-BYTE_W){fill}}, rdata_sh[BYTE_W-1:0]};
      end
    endcase
  end

  ////////////////////////////// result hold

  // stores get an rvalid too but leave the result alone
  assign load_rvalid = mem_rvalid_i & ~ctx_q.we;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      rdata_q <= '0;
    else if (load_rvalid)
      rdata_q <= rdata_ext;
  end

  // fresh data straight through, held copy otherwise
  assign ex_rdata_o = load_rvalid ? rdata_ext : rdata_q;

endmodule

`default_nettype wire

// File: hw/lsu_top.sv
// mem_req_o is valid only with mem_req_valid_o, and misaligned_o is meaningful only with a request
`timescale 1ns/1ps
`default_nettype none

module lsu_top
  import lsu_pkg::*;
(
  input  logic            clk,
  input  logic            rst_n,

  ////////////////////////////// execute stage

  input  lsu_req_t        ex_req_i,        // operands, size and store data
  input  logic            ex_req_valid_i,
  input  logic            ex_valid_i,      // low while ex is stalled
  output logic [XLEN-1:0] ex_rdata_o,      // load result
  output logic            ready_ex_o,
  output logic            ready_wb_o,
  output logic            misaligned_o,    // crossing access, dropped
  output logic            busy_o,

  ////////////////////////////// data memory

  output mem_req_t        mem_req_o,
  output logic            mem_req_valid_o,
  input  logic            mem_gnt_i,
  input  logic            mem_rvalid_i,
  input  logic            mem_err_i,
  input  logic [XLEN-1:0] mem_rdata_i
);

  rd_ctx_t fmt_ctx;        // load context of the current request
  logic    fmt_misaligned; // boundary flag from the formatter

  // address, lanes and boundary check
  lsu_req_fmt req_fmt_i (
    .ex_req_i     (ex_req_i),
    .mem_req_o    (mem_req_o),
    .ctx_o        (fmt_ctx),
    .misaligned_o (fmt_misaligned)
  );

  // request handshake and stall tracking
  lsu_ctrl_fsm ctrl_fsm_i (
    .clk             (clk),
    .rst_n           (rst_n),
    .ex_req_valid_i  (ex_req_valid_i),
    .misaligned_i    (fmt_misaligned),
    .mem_gnt_i       (mem_gnt_i),
    .mem_rvalid_i    (mem_rvalid_i),
    .mem_err_i       (mem_err_i),
    .ex_valid_i      (ex_valid_i),
    .mem_req_valid_o (mem_req_valid_o),
    .ready_ex_o      (ready_ex_o),
    .ready_wb_o      (ready_wb_o),
    .busy_o          (busy_o)
  );

  // load data path
  lsu_rdata_align rdata_align_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .ctx_i        (fmt_ctx),
    .mem_gnt_i    (mem_gnt_i),
    .mem_rvalid_i (mem_rvalid_i),
    .mem_rdata_i  (mem_rdata_i),
    .ex_rdata_o   (ex_rdata_o)
  );

  assign misaligned_o = fmt_misaligned; // also seen by the FSM

endmodule

`default_nettype wire

// File: dv/lsu_chk.sv
// watches the memory side only, every property is off while rst_n is low
`timescale 1ns/1ps
`default_nettype none

module lsu_chk
  import lsu_pkg::*;
(
  input logic            clk,
  input logic            rst_n,
  input lsu_state_e      state_i,         // request FSM state
  input logic            mem_req_valid_i,
  input logic [XLEN-1:0] mem_addr_i,
  input logic            mem_gnt_i,
  input logic            mem_rvalid_i
);

  logic waiting; // granted access not yet answered

  assign waiting = (state_i == ST_WAIT_RVALID) || (state_i == ST_WAIT_RVALID_STALL);

  ////////////////////////////// handshake

  // idle means nothing outstanding
  a_no_rvalid_idle: assert property (@(posedge clk) disable iff (!rst_n)
    (state_i == ST_IDLE) |-> !mem_rvalid_i)
    else $error("rvalid seen while the FSM is idle");

  a_no_early_gnt: assert property (@(posedge clk) disable iff (!rst_n)
    (waiting && mem_gnt_i) |-> mem_rvalid_i) // second access only once data is back
    else $error("grant while an access still waits for rvalid");

  a_addr_known: assert property (@(posedge clk) disable iff (!rst_n)
    mem_req_valid_i |-> !$isunknown(mem_addr_i))
    else $error("request issued with an unknown address");

endmodule

`default_nettype wire

// File: dv/tb_lsu.sv
// one access at a time and dv/lsu_patterns.hex is read relative to the directory the run starts in
`timescale 1ns/1ps
`default_nettype none

module tb_lsu
  import lsu_pkg::*;
();

  localparam int          N_PAT      = 18;                        // lines in the pattern file
  localparam int          N_COL      = 14;                        // values per line
  localparam int          RST_CYCLES = 4;
  localparam int          MAX_CYCLES = N_PAT * 12 + RST_CYCLES + 2; // worst access is under 12
  localparam logic [31:0] LFSR_SEED  = 32'h5940;
  localparam logic [31:0] LFSR_TAPS  = 32'h8020_0003;            // x^32 + x^22 + x^2 + x + 1

  logic            clk;
  logic            rst_n;
  lsu_req_t        ex_req_i;
  logic            ex_req_valid_i, ex_valid_i;
  logic [XLEN-1:0] ex_rdata_o;
  logic            ready_ex_o, ready_wb_o, misaligned_o, busy_o;
  mem_req_t        mem_req_o;
  logic            mem_req_valid_o, mem_gnt_i, mem_rvalid_i, mem_err_i;
  logic [XLEN-1:0] mem_rdata_i;

  logic [31:0] pat_mem [0:N_PAT*N_COL-1]; // stimulus and expected values
  logic [31:0] lfsr;                      // responder timing source
  int          stall_left;                // ex stall cycles still to go
  int          cycles;

  lsu_top dut_i (.*);

  bind lsu_top lsu_chk chk_i (
    .clk             (clk),
    .rst_n           (rst_n),
    .state_i         (ctrl_fsm_i.state_q),
    .mem_req_valid_i (mem_req_valid_o),
    .mem_addr_i      (mem_req_o.addr),
    .mem_gnt_i       (mem_gnt_i),
    .mem_rvalid_i    (mem_rvalid_i)
  );

  initial
  begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  ////////////////////////////// helpers

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    lfsr_step = s[0] ? ((s >> 1) ^ LFSR_TAPS) : (s >> 1);
  endfunction

  // one lfsr step per bit with msb first
  task automatic draw_bits(input int n, output int v);
    int i;
    v = 0;
    for (i = 0; i < n; i++)
    begin
      lfsr = lfsr_step(lfsr);
      v    = (v << 1) | int'(lfsr[0]);
    end
  endtask

  task automatic check_val(input string name, input logic [31:0] exp_v, input logic [31:0] got_v);
    if (exp_v !== got_v)
    begin
      $display("Mismatch %s exp=%h got=%h", name, exp_v, got_v);
      $display("Test FAILED");
      $fatal(1, "stopped at first error");
    end
  endtask

  // next cycle with inputs changed 1 ns after the edge
  task automatic advance();
    @(posedge clk);
    #1;
    if (stall_left > 0)
      stall_left--;
    ex_valid_i = (stall_left == 0);
  endtask

  task automatic run_access(input int idx);
    int          base;
    logic [31:0] p [N_COL]; // we size ext incr err op_a op_b wdata rdata addr be wdata mis res
    int          gnt_dly, rv_dly, stall, stall_len, k, j;
    logic        accepted;
    base = idx * N_COL;
    for (k = 0; k < N_COL; k++)
      p[k] = pat_mem[base + k];
    draw_bits(2, gnt_dly);   // 0..3 cycles to grant
    draw_bits(2, rv_dly);
    rv_dly = 1 + rv_dly % 3; // 1..3 cycles grant to rvalid
    draw_bits(1, stall);
    draw_bits(1, stall_len);
    stall_len = stall_len + 1;
    if (p[4][0])
      stall = 0;             // bus error gets no stall spell

    ex_req_i.we       = p[0][0];
    ex_req_i.size     = lsu_size_e'(p[1][1:0]);
    ex_req_i.ext      = lsu_ext_e'(p[2][1:0]);
    ex_req_i.use_incr = p[3][0];
    ex_req_i.op_a     = p[5];
    ex_req_i.op_b     = p[6];
    ex_req_i.wdata    = p[7];
    ex_req_valid_i    = 1'b1;

    if (p[12][0])
    begin
      // crossing access is dropped in the same cycle
      @(negedge clk);
      check_val("misaligned_o", 32'd1, 32'(misaligned_o));
      check_val("mem_req_valid_o", 32'd0, 32'(mem_req_valid_o));
      check_val("ready_ex_o", 32'd1, 32'(ready_ex_o));
      advance();
      ex_req_valid_i = 1'b0;
    end
    else
    begin
      k        = 0;
      accepted = 1'b0;
      while (!accepted)
      begin
        if (k == gnt_dly)
        begin
          mem_gnt_i  = ~p[4][0];
          mem_err_i  = p[4][0];
          ex_valid_i = (stall == 0);
          stall_left = (stall != 0) ? stall_len : 0;
        end
        @(negedge clk);
        check_val("mem_req_valid_o", 32'd1, 32'(mem_req_valid_o));
        check_val("misaligned_o", 32'd0, 32'(misaligned_o));
        check_val("busy_o", 32'd1, 32'(busy_o));
        check_val("mem_req_o.addr", p[9], mem_req_o.addr);
        check_val("mem_req_o.we", p[0], 32'(mem_req_o.we));
        check_val("mem_req_o.be", p[10], 32'(mem_req_o.be));
        if (p[0][0])
          check_val("mem_req_o.wdata", p[11], mem_req_o.wdata);
        check_val("ready_ex_o", 32'(k == gnt_dly), 32'(ready_ex_o));
        accepted = ready_ex_o;
        advance();
        k++;
      end
      mem_gnt_i      = 1'b0;
      mem_err_i      = 1'b0;
      ex_req_valid_i = 1'b0;
      for (j = 1; j <= rv_dly && !p[4][0]; j++)
      begin
        if (j == rv_dly)
        begin
          mem_rvalid_i = 1'b1;
          mem_rdata_i  = p[8];
        end
        @(negedge clk);
        check_val("busy_o", 32'd1, 32'(busy_o));
        if (stall == 0)
          check_val("ready_wb_o", 32'(j == rv_dly), 32'(ready_wb_o));
        if (j == rv_dly && !p[0][0])
          check_val("ex_rdata_o", p[13], ex_rdata_o); // fresh load data
        advance();
      end
      mem_rvalid_i = 1'b0;
      mem_rdata_i  = '0;
    end

    // back to idle while the held result stays
    @(negedge clk);
    while (busy_o)
    begin
      advance();
      @(negedge clk);
    end
    check_val("ready_ex_o", 32'd1, 32'(ready_ex_o));
    check_val("ready_wb_o", 32'd1, 32'(ready_wb_o));
    check_val("mem_req_valid_o", 32'd0, 32'(mem_req_valid_o));
    check_val("ex_rdata_o", p[13], ex_rdata_o);
    advance();
  endtask

  ////////////////////////////// watchdog

  initial
  begin
    cycles = 0;
    while (cycles < MAX_CYCLES)
    begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout after %0d cycles, the DUT stopped answering", cycles);
    $display("Test FAILED");
    $fatal(1, "timeout");
  end

  ////////////////////////////// main sequence

  initial
  begin
    int i;
    rst_n          = 1'b0;
    ex_req_i       = '0;
    ex_req_valid_i = 1'b0;
    ex_valid_i     = 1'b1;
    mem_gnt_i      = 1'b0;
    mem_rvalid_i   = 1'b0;
    mem_err_i      = 1'b0;
    mem_rdata_i    = '0;
    lfsr           = LFSR_SEED;
    stall_left     = 0;
    $readmemh("dv/lsu_patterns.hex", pat_mem);

    repeat (RST_CYCLES - 1) @(posedge clk);
    @(negedge clk);
    check_val("busy_o", 32'd0, 32'(busy_o));
    check_val("mem_req_valid_o", 32'd0, 32'(mem_req_valid_o));
    check_val("ready_ex_o", 32'd1, 32'(ready_ex_o));
    check_val("ready_wb_o", 32'd1, 32'(ready_wb_o));
    check_val("ex_rdata_o", 32'd0, ex_rdata_o);
    advance();
    rst_n = 1'b1;

    for (i = 0; i < N_PAT; i++)
      run_access(i);

    $display("Test OK");
    $finish;
  end

endmodule

`default_nettype wire

// File: dv/lsu_patterns.hex
// we size ext use_incr err | op_a op_b wdata | mem word | exp addr be wdata misaligned | exp result
// size 0 word 1 half 2 byte, ext 0 zero 1 sign 2 ones, err 1 answers with a bus error
1 0 0 0 0 00001000 00000000 a5a51234 00000000 00001000 f a5a51234 0 00000000
0 0 0 1 0 00002000 00000010 00000000 cafef00d 00002010 f 00000000 0 cafef00d
1 1 0 1 0 00003001 00000001 0000beef 00000000 00003002 c beef0000 0 cafef00d
1 2 0 0 0 00004003 00000000 11223344 00000000 00004003 8 44112233 0 cafef00d
1 2 0 1 0 00004000 00000001 000000ab 00000000 00004001 2 0000ab00 0 cafef00d
0 1 1 0 0 00005000 00000000 00000000 12348765 00005000 3 00000000 0 ffff8765
0 1 0 0 0 00005002 00000000 00000000 87651234 00005002 c 00000000 0 00008765
0 1 2 1 0 00005000 00000002 00000000 0042ffff 00005002 c 00000000 0 ffff0042
0 2 1 0 0 00006001 00000000 00000000 00008000 00006001 2 00000000 0 ffffff80
0 2 0 0 0 00006003 00000000 00000000 9a000000 00006003 8 00000000 0 0000009a
0 2 2 1 0 00006000 00000002 00000000 00550000 00006002 4 00000000 0 ffffff55
0 2 1 0 0 00006000 00000000 00000000 0000007f 00006000 1 00000000 0 0000007f
0 0 0 0 0 00007001 00000000 00000000 00000000 00007001 f 00000000 1 0000007f
1 1 0 1 0 00007000 00000003 00001234 00000000 00007003 0 00000000 1 0000007f
0 0 0 0 1 00008000 00000000 00000000 00000000 00008000 f 00000000 0 0000007f
0 1 1 0 0 00009000 00000000 00000000 0000c001 00009000 3 00000000 0 ffffc001
0 0 2 1 0 0000a000 00000004 00000000 01234567 0000a004 f 00000000 0 01234567
1 2 0 1 0 fffffffe 00000004 000000c3 00000000 00000002 4 00c30000 0 01234567

// File: lsu.f
hw/lsu_pkg.sv
hw/lsu_req_fmt.sv
hw/lsu_ctrl_fsm.sv
hw/lsu_rdata_align.sv
hw/lsu_top.sv
dv/lsu_chk.sv
dv/tb_lsu.sv

// File: Makefile
TOP = tb_lsu

sim:
	verilator --binary --timing --assert -f lsu.f --top-module $(TOP) -o sim_$(TOP)
	./obj_dir/sim_$(TOP) | tee sim.log
	grep -q "Test OK" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean
